/* filelist.f */
+incdir+src
src/apb_pkg.sv
src/video_pkg.sv
src/linear_table.sv
src/scaler_h.sv
src/scaler_regs.sv
src/scaler_top.sv
tests/scaler_asserts.sv
tests/scaler_tb.sv

/* src/apb_pkg.sv */
`include "scaler_defs.svh"

package apb_pkg;

    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [31:0]                pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // LINE_CNT is read-only
    typedef enum logic [`APB_ADDR_WIDTH-1:0] {
        CTRL     = 'h0,
        STEP     = 'h4,
        LINE_CNT = 'h8
    } reg_addr_e;

endpackage

/* src/linear_table.sv */
`include "scaler_defs.svh"

module linear_table (
    input  logic                             clk,
    input  logic [$clog2(`PIXEL_STEP/2)-1:0] dx_i,
    output logic [`COE_WIDTH-1:0]            coe0_o,
    output logic [`COE_WIDTH-1:0]            coe1_o
);

    localparam int DX_WIDTH    = $clog2(`PIXEL_STEP / 2);
    localparam int PROD_WIDTH  = DX_WIDTH + `COE_WIDTH;
    localparam int FULL_WEIGHT = 1 << (`COE_WIDTH - 1);

    // weights of one output pixel sum to this
    localparam logic [`COE_WIDTH-1:0] COE_FULL = FULL_WEIGHT[`COE_WIDTH-1:0];

    logic [PROD_WIDTH-1:0] prod;
    logic [`COE_WIDTH-1:0] coe1_next;
    logic [`COE_WIDTH-1:0] coe0_next;

    // dx spans 0..1 of a pixel
    assign prod      = dx_i * COE_FULL;
    // scale back by the dx range, max is one step below full weight
    assign coe1_next = prod[DX_WIDTH +: `COE_WIDTH];
    assign coe0_next = COE_FULL - coe1_next;

    always_ff @(posedge clk) begin
        coe0_o <= coe0_next;
        coe1_o <= coe1_next;
    end

endmodule

/* src/scaler_defs.svh */
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

// fixed-point value of a scale of 1.0
`define PIXEL_STEP 4096

// bits per pixel sample
`define PIXEL_WIDTH 12

// interpolation weight bits
`define COE_WIDTH 10

// scale step register bits
`define STEP_WIDTH 16

// byte address of the register block
`define APB_ADDR_WIDTH 4

`endif

/* src/scaler_h.sv */
`include "scaler_defs.svh"

module scaler_h
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  scaler_cfg_t cfg_i,
    input  video_beat_t video_i,
    output video_beat_t video_o,
    output logic        line_done_o,
    output logic [15:0] line_out_cnt_o
);

    localparam int CNT_WIDTH  = 24;
    localparam int DX_WIDTH   = $clog2(`PIXEL_STEP / 2);
    localparam int MULT_WIDTH = `COE_WIDTH + `PIXEL_WIDTH;
    localparam int SUM_WIDTH  = MULT_WIDTH + 1;

    // half of the full weight
    localparam logic [SUM_WIDTH-1:0] ROUND_ADDER = SUM_WIDTH'(1 << (`COE_WIDTH - 2));
    localparam logic [`PIXEL_WIDTH-1:0] PIXEL_MAX = '1;
    localparam logic [CNT_WIDTH-1:0] CNT_ONE = CNT_WIDTH'(`PIXEL_STEP);

    // coordinates in PIXEL_STEP units
    logic [CNT_WIDTH-1:0]    cnt_i;
    logic [CNT_WIDTH-1:0]    cnt_o;
    logic                    due;
    logic                    line_start;
    logic                    frame_start;
    logic                    sol;
    logic                    sof;
    logic                    new_pix;
    logic                    new_line;
    logic                    new_fr;
    logic [`PIXEL_WIDTH-1:0] last_pix [2];
    logic [`PIXEL_WIDTH-1:0] pix_new;
    logic [`PIXEL_WIDTH-1:0] pix_old;
    logic [DX_WIDTH-1:0]     dx;
    logic [`COE_WIDTH-1:0]   coe0;
    logic [`COE_WIDTH-1:0]   coe1;
    logic [MULT_WIDTH-1:0]   mult_old;
    logic [MULT_WIDTH-1:0]   mult_new;
    logic [SUM_WIDTH-1:0]    sum;
    logic [`PIXEL_WIDTH-1:0] pix_sat;
    logic [1:0]              de_sr;
    logic [1:0]              hs_sr;
    logic [1:0]              vs_sr;
    video_beat_t             byp_q [2];
    logic                    out_inc;
    logic [15:0]             out_cnt;

    assign line_start  = video_i.de & video_i.hs;
    assign frame_start = video_i.de & video_i.vs;

    // output position reached by the input
    assign due = cnt_i >= cnt_o;

    always_ff @(posedge clk) begin
        if (video_i.de) begin
            last_pix[0] <= video_i.pixel;
            last_pix[1] <= last_pix[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_i    <= '0;
            cnt_o    <= CNT_ONE;
            sol      <= 1'b0;
            sof      <= 1'b0;
            new_pix  <= 1'b0;
            new_line <= 1'b0;
            new_fr   <= 1'b0;
        end else begin
            new_pix  <= due;
            new_line <= due & sol;
            new_fr   <= due & sof;

            // line start restarts both coordinates
            if (line_start) begin
                cnt_i <= '0;
                cnt_o <= CNT_ONE;
            end else begin
                if (video_i.de) begin
                    cnt_i <= cnt_i + CNT_ONE;
                end
                if (due) begin
                    cnt_o <= cnt_o + CNT_WIDTH'(cfg_i.step);
                end
            end

            // sync flags wait for the next output
            if (line_start) begin
                sol <= 1'b1;
            end else if (due) begin
                sol <= 1'b0;
            end
            if (frame_start) begin
                sof <= 1'b1;
            end else if (due) begin
                sof <= 1'b0;
            end
        end
    end

    // neighbours of the output position
    always_ff @(posedge clk) begin
        if (due) begin
            pix_new <= last_pix[0];
            pix_old <= last_pix[1];
        end
    end

    // fraction of the output coordinate, half resolution
    assign dx = cnt_o[1 +: DX_WIDTH];

    linear_table u_table (
        .clk    (clk),
        .dx_i   (dx),
        .coe0_o (coe0),
        .coe1_o (coe1)
    );

    always_ff @(posedge clk) begin
        mult_old <= coe0 * pix_old;
        mult_new <= coe1 * pix_new;
        sum      <= mult_old + mult_new + ROUND_ADDER;
    end

    // clamp to full scale
    assign pix_sat = (|sum[SUM_WIDTH-1:MULT_WIDTH-1]) ? PIXEL_MAX
                                                       : sum[`COE_WIDTH-1 +: `PIXEL_WIDTH];

    // strobes follow the multiply-add stages
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_sr    <= '0;
            hs_sr    <= '0;
            vs_sr    <= '0;
            byp_q[0] <= '0;
            byp_q[1] <= '0;
        end else begin
            de_sr    <= {de_sr[0], new_pix};
            hs_sr    <= {hs_sr[0], new_line};
            vs_sr    <= {vs_sr[0], new_fr};
            byp_q[0] <= video_i;
            byp_q[1] <= byp_q[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            video_o.de <= 1'b0;
            video_o.hs <= 1'b0;
            video_o.vs <= 1'b0;
        end else if (cfg_i.bypass) begin
            video_o <= byp_q[1];
        end else begin
            video_o.de <= de_sr[1];
            video_o.hs <= hs_sr[1];
            video_o.vs <= vs_sr[1];
            if (de_sr[1]) begin
                video_o.pixel <= pix_sat;
            end
        end
    end

    // outputs per line, input beats in bypass
    assign out_inc = cfg_i.bypass ? video_i.de : due;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_cnt        <= '0;
            line_done_o    <= 1'b0;
            line_out_cnt_o <= '0;
        end else begin
            line_done_o <= line_start;
            if (line_start) begin
                // a decision in this cycle still belongs to the old line
                line_out_cnt_o <= cfg_i.bypass ? out_cnt : out_cnt + 16'(due);
                out_cnt        <= cfg_i.bypass ? 16'd1 : 16'd0;
            end else if (out_inc) begin
                out_cnt <= out_cnt + 16'd1;
            end
        end
    end

endmodule

/* src/scaler_regs.sv */
`include "scaler_defs.svh"

module scaler_regs
    import apb_pkg::*;
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  apb_req_t    apb_i,
    output apb_rsp_t    apb_o,
    output scaler_cfg_t cfg_o,
    input  logic        line_done_i,
    input  logic [15:0] line_out_cnt_i
);

    reg_addr_e   addr;
    logic        setup;
    logic        access;
    logic        wr_err;
    logic [31:0] rd_data;
    logic [31:0] prdata_q;
    logic        pslverr_q;
    scaler_cfg_t cfg_q;
    logic [15:0] line_cnt_q;

    assign addr   = reg_addr_e'(apb_i.paddr);
    assign setup  = apb_i.psel & ~apb_i.penable;
    assign access = apb_i.psel & apb_i.penable;

    // address decode, read mux and write legality
    always_comb begin
        wr_err  = 1'b0;
        rd_data = '0;
        case (addr)
            CTRL: begin
                rd_data = {31'b0, cfg_q.bypass};
            end
            STEP: begin
                rd_data = 32'(cfg_q.step);
                // no upscaling
                wr_err  = apb_i.pwdata[`STEP_WIDTH-1:0] < `STEP_WIDTH'(`PIXEL_STEP);
            end
            LINE_CNT: begin
                rd_data = 32'(line_cnt_q);
                wr_err  = 1'b1;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pslverr_q    <= 1'b0;
            cfg_q.step   <= `STEP_WIDTH'(`PIXEL_STEP);
            cfg_q.bypass <= 1'b0;
            line_cnt_q   <= '0;
        end else begin
            // error decided in setup, shown during access
            pslverr_q <= setup & apb_i.pwrite & wr_err;

            if (line_done_i) begin
                line_cnt_q <= line_out_cnt_i;
            end

            // rejected writes leave the registers alone
            if (access && apb_i.pwrite && !pslverr_q) begin
                if (addr == CTRL) begin
                    cfg_q.bypass <= apb_i.pwdata[0];
                end else if (addr == STEP) begin
                    cfg_q.step <= apb_i.pwdata[`STEP_WIDTH-1:0];
                end
            end
        end
    end

    // read data captured in setup
    always_ff @(posedge clk) begin
        if (setup) begin
            prdata_q <= rd_data;
        end
    end

    assign apb_o.prdata  = prdata_q;
    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = pslverr_q;

    assign cfg_o = cfg_q;

endmodule

/* src/scaler_top.sv */
module scaler_top
    import apb_pkg::*;
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  apb_req_t    apb_i,
    output apb_rsp_t    apb_o,
    input  video_beat_t video_i,
    output video_beat_t video_o
);

    scaler_cfg_t cfg;
    logic        line_done;
    logic [15:0] line_out_cnt;

    // register block beside the datapath
    scaler_regs u_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .apb_i          (apb_i),
        .apb_o          (apb_o),
        .cfg_o          (cfg),
        .line_done_i    (line_done),
        .line_out_cnt_i (line_out_cnt)
    );

    scaler_h u_scaler (
        .clk            (clk),
        .reset_i        (reset_i),
        .cfg_i          (cfg),
        .video_i        (video_i),
        .video_o        (video_o),
        .line_done_o    (line_done),
        .line_out_cnt_o (line_out_cnt)
    );

endmodule

/* src/video_pkg.sv */
`include "scaler_defs.svh"

package video_pkg;

    // one beat of the pixel stream
    typedef struct packed {
        logic [`PIXEL_WIDTH-1:0] pixel;
        // pixel valid
        logic                    de;
        // first pixel of a line, with de
        logic                    hs;
        // first pixel of a frame, with de
        logic                    vs;
    } video_beat_t;

    // scaler settings from the register block
    typedef struct packed {
        // unsigned fixed point, PIXEL_STEP is 1.0
        logic [`STEP_WIDTH-1:0] step;
        logic                   bypass;
    } scaler_cfg_t;

endpackage

/* tests/scaler_asserts.sv */
`include "scaler_defs.svh"

module scaler_asserts
    import apb_pkg::*;
    import video_pkg::*;
(
    input logic        clk,
    input logic        reset_i,
    input apb_rsp_t    apb_o,
    input video_beat_t video_i,
    input video_beat_t video_o,
    input scaler_cfg_t cfg,
    input logic        line_done
);

    timeunit 1ns;
    timeprecision 1ps;

    // failures seen so far, read by the testbench
    int fail_cnt = 0;

    // two most recent input pixels
    logic [`PIXEL_WIDTH-1:0] shadow0;
    logic [`PIXEL_WIDTH-1:0] shadow1;

    always_ff @(posedge clk) begin
        if (video_i.de) begin
            shadow0 <= video_i.pixel;
            shadow1 <= shadow0;
        end
    end

    // outputs idle right after reset
    reset_state: assert property (@(posedge clk)
        $fell(reset_i) |-> !video_o.de && !video_o.hs && !video_o.vs
                           && !apb_o.pslverr && !line_done)
    else begin
        $error("outputs not idle after reset");
        fail_cnt++;
    end

    // unity step copies the older neighbour of the decision
    unity_pixel: assert property (@(posedge clk) disable iff (reset_i)
        (video_o.de && !cfg.bypass && !$past(cfg.bypass)
         && cfg.step == `PIXEL_STEP && $past(cfg.step, 4) == `PIXEL_STEP)
        |-> video_o.pixel == $past(shadow1, 4))
    else begin
        $error("unity step pixel differs from shadow");
        fail_cnt++;
    end

    hs_with_de: assert property (@(posedge clk) disable iff (reset_i)
        video_o.hs |-> video_o.de)
    else begin
        $error("hs_o without de_o");
        fail_cnt++;
    end

    vs_with_hs: assert property (@(posedge clk) disable iff (reset_i)
        video_o.vs |-> video_o.hs ##1 !video_o.vs)
    else begin
        $error("vs_o without hs_o or longer than one beat");
        fail_cnt++;
    end

    // bypass delays the whole beat by three cycles
    bypass_delay: assert property (@(posedge clk) disable iff (reset_i)
        (cfg.bypass && $past(cfg.bypass)) |-> video_o == $past(video_i, 3))
    else begin
        $error("bypass output differs from delayed input");
        fail_cnt++;
    end

endmodule

bind scaler_top scaler_asserts u_asserts (.*);

/* tests/scaler_tb.sv */
`include "scaler_defs.svh"

module scaler_tb
    import apb_pkg::*;
    import video_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 100;

    logic        clk;
    logic        reset_i;
    apb_req_t    apb_i;
    apb_rsp_t    apb_o;
    video_beat_t video_i;
    video_beat_t video_o;

    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          mark;

    scaler_top DUT (
        .clk     (clk),
        .reset_i (reset_i),
        .apb_i   (apb_i),
        .apb_o   (apb_o),
        .video_i (video_i),
        .video_o (video_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // outputs of a line of n pixels followed by blanking
    function automatic int line_output_count(input int n, input int step);
        return ((n - 2) * `PIXEL_STEP) / step + 1;
    endfunction

    function automatic int fail_total();
        return errors + DUT.u_asserts.fail_cnt;
    endfunction

    task automatic abort_run(input string what);
        $display("%s at %0t", what, $time);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int t;
        @(posedge clk);
        apb_i <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_i.penable <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!apb_o.pready && t < TIMEOUT);
        if (!apb_o.pready) begin
            abort_run("no pready from the APB slave");
        end else begin
            rdata = apb_o.prdata;
            err   = apb_o.pslverr;
            @(posedge clk);
            apb_i <= '0;
        end
    endtask

    task automatic check_read(input logic [3:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] d;
        logic        e;
        apb_xfer(1'b0, addr, '0, d, e);
        if (d !== exp || e !== 1'b0) begin
            $display("[ERROR] %0t read %s got %0d err %b, expected %0d", $time, name, d, e, exp);
            errors++;
        end
    endtask

    task automatic check_write(input logic [3:0] addr, input logic [31:0] wdata,
                               input logic exp_err, input string name);
        logic [31:0] d;
        logic        e;
        apb_xfer(1'b1, addr, wdata, d, e);
        if (e !== exp_err) begin
            $display("[ERROR] %0t write %s pslverr %b, expected %b", $time, name, e, exp_err);
            errors++;
        end
    endtask

    task automatic send_line(input int n, input logic first_of_frame);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            video_i <= '{pixel: `PIXEL_WIDTH'(take_bits(`PIXEL_WIDTH)), de: 1'b1,
                         hs: (i == 0), vs: (i == 0) && first_of_frame};
        end
        // blanking long enough for the trailing outputs
        repeat (n + 16) begin
            @(posedge clk);
            video_i <= '0;
        end
    endtask

    // LINE_CNT is latched at the start of the following line
    task automatic check_line_count(input int n, input int step);
        int exp;
        exp = line_output_count(n, step);
        send_line(n, 1'b0);
        send_line(2, 1'b0);
        check_read(LINE_CNT, exp, "LINE_CNT");
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (fail_total() != mark) begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: PASS", name);
        end
        mark = fail_total();
    endtask

    initial begin
        int n;
        int prev_n;
        int cur_n;
        int cnt_exp;
        lfsr         = 32'd90513;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        mark         = 0;
        reset_i      = 1'b1;
        apb_i        = '0;
        video_i      = '0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        check_read(STEP, `PIXEL_STEP, "STEP");
        check_read(CTRL, 0, "CTRL");
        check_read(LINE_CNT, 0, "LINE_CNT");
        report_test("reset_state");

        send_line(20, 1'b1);
        for (int i = 0; i < 3; i++) begin
            n = 8 + take_bits(5);
            check_line_count(n, `PIXEL_STEP);
        end
        report_test("unity_step");

        for (int k = 0; k < 2; k++) begin
            int step;
            step = (k == 0) ? 2 * `PIXEL_STEP : 3 * `PIXEL_STEP / 2;
            check_write(STEP, step, 1'b0, "STEP");
            send_line(12, 1'b1);
            for (int i = 0; i < 4; i++) begin
                n = 4 + take_bits(6);
                check_line_count(n, step);
            end
        end
        report_test("downscale_count");

        // two frames of short lines
        prev_n = 0;
        cur_n  = 0;
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < 3; i++) begin
                prev_n = cur_n;
                cur_n  = 10 + take_bits(3);
                send_line(cur_n, i == 0);
            end
        end
        report_test("sync_alignment");

        // LINE_CNT holds the count of the second last line
        cnt_exp = line_output_count(prev_n, 3 * `PIXEL_STEP / 2);
        check_write(STEP, 100, 1'b1, "STEP below unity");
        check_read(STEP, 3 * `PIXEL_STEP / 2, "STEP");
        check_read(LINE_CNT, cnt_exp, "LINE_CNT");
        check_write(LINE_CNT, 55, 1'b1, "LINE_CNT");
        check_read(LINE_CNT, cnt_exp, "LINE_CNT");
        report_test("illegal_writes");

        check_write(CTRL, 1, 1'b0, "CTRL");
        check_read(CTRL, 1, "CTRL");
        for (int i = 0; i < 3; i++) begin
            send_line(6 + take_bits(4), i == 0);
        end
        check_write(CTRL, 0, 1'b0, "CTRL");
        report_test("bypass");

        repeat (10) @(posedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, fail_total());
        if (fail_total() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // guard against a stalled run
    initial begin
        #20ms;
        abort_run("simulation time limit reached");
    end

endmodule
